//--- src/cosPkg.sv
// Shared widths, address map, reset timing and bus structs of the control shell, used by scoped names
package cosPkg;

  // ******************************
  // Widths
  // ******************************
  localparam int DataW = 32;
  localparam int AddrW = 12;
  localparam int BlockW = 4;
  localparam int RegW = 6;
  localparam int LedMaxW = 8;

  // ******************************
  // Address map
  // ******************************
  localparam logic [BlockW-1:0] BlockTree = 4'd0;
  localparam logic [BlockW-1:0] BlockLed = 4'd1;
  localparam logic [BlockW-1:0] BlockGpio = 4'd2;

  // Tree control registers
  localparam logic [RegW-1:0] RegId = 6'd0;
  localparam logic [RegW-1:0] RegScratch = 6'd1;
  localparam logic [RegW-1:0] RegReset = 6'd2;
  localparam logic [DataW-1:0] CosIdValue = 32'hC05E_0100;

  // GPIO registers
  localparam logic [RegW-1:0] RegGpioOut = 6'd0;
  localparam logic [RegW-1:0] RegGpioTristate = 6'd1;
  localparam logic [RegW-1:0] RegGpioIn = 6'd2;

  // Reset timing, in clock cycles
  localparam int ResetCycles = 32;
  localparam int ResetStartCycles = 8;

  // AXI response codes
  localparam logic [1:0] RespOkay = 2'd0;
  localparam logic [1:0] RespSlvErr = 2'd2;

  // ******************************
  // Bus structs
  // ******************************
  typedef struct packed {
    logic awValid;
    logic [AddrW-1:0] awAddr;
    logic wValid;
    logic [DataW-1:0] wData;
    logic bReady;
    logic arValid;
    logic [AddrW-1:0] arAddr;
    logic rReady;
  } axilReqT;

  typedef struct packed {
    logic awReady;
    logic wReady;
    logic bValid;
    logic [1:0] bResp;
    logic arReady;
    logic rValid;
    logic [DataW-1:0] rData;
    logic [1:0] rResp;
  } axilRspT;

  typedef struct packed {
    logic valid;
    logic write;
    logic [BlockW-1:0] block;
    logic [RegW-1:0] regIdx;
    logic [DataW-1:0] wData;
  } csrReqT;

  typedef struct packed {
    logic ready;
    logic error;
    logic [DataW-1:0] rData;
  } csrRspT;

endpackage

//--- src/cosResetStretch.sv
// Internal reset generator; merges the board reset with CSR soft-reset requests and stretches it
`timescale 1ns/1ps

module cosResetStretch (
  input  logic clock,
  input  logic arstN,
  input  logic resetRequest,
  output logic resetTop
);

  localparam int StartW = $clog2(cosPkg::ResetStartCycles + 1);
  localparam int HoldW = $clog2(cosPkg::ResetCycles + 1);

  logic [StartW-1:0] startCount;
  logic [HoldW-1:0] holdCount;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      startCount <= '0;
      holdCount <= HoldW'(cosPkg::ResetCycles);
      resetTop <= 1'b1;
    end else begin
      // Start delay, lets the write response of the reset command drain
      if (startCount != '0) begin
        startCount <= startCount - 1'b1;
      end else if (resetRequest && !resetTop) begin
        startCount <= StartW'(cosPkg::ResetStartCycles);
      end
      // Hold phase
      if (startCount == StartW'(1)) begin
        holdCount <= HoldW'(cosPkg::ResetCycles);
        resetTop <= 1'b1;
      end else if (holdCount != '0) begin
        holdCount <= holdCount - 1'b1;
        if (holdCount == HoldW'(1)) begin
          resetTop <= 1'b0;
        end
      end
    end
  end

endmodule

//--- src/cosAxilControl.sv
// AXI4-Lite slave front end; turns each host transaction into one CSR request to the splitter
`timescale 1ns/1ps

module cosAxilControl (
  input  logic clock,
  input  logic arstN,
  input  logic resetTop,
  input  cosPkg::axilReqT axilReq,
  output cosPkg::axilRspT axilRsp,
  output cosPkg::csrReqT csrReq,
  input  cosPkg::csrRspT csrRsp
);

  typedef enum logic [1:0] {
    StIdle,
    StRequest,
    StRespWrite,
    StRespRead
  } stateT;

  stateT state;
  logic writeGo;
  logic readGo;
  logic reqWrite;
  logic [cosPkg::BlockW-1:0] reqBlock;
  logic [cosPkg::RegW-1:0] reqReg;
  logic [cosPkg::DataW-1:0] reqWData;
  logic [cosPkg::DataW-1:0] rDataQ;
  logic [1:0] respCode;

  // Write needs both address and data; any write activity blocks a read
  assign writeGo = (state == StIdle) && !resetTop && axilReq.awValid && axilReq.wValid;
  assign readGo = (state == StIdle) && !resetTop && axilReq.arValid &&
                  !axilReq.awValid && !axilReq.wValid;

  always_comb begin
    axilRsp.awReady = writeGo;
    axilRsp.wReady = writeGo;
    axilRsp.arReady = readGo;
    axilRsp.bValid = (state == StRespWrite);
    axilRsp.bResp = respCode;
    axilRsp.rValid = (state == StRespRead);
    axilRsp.rData = rDataQ;
    axilRsp.rResp = respCode;
    csrReq.valid = (state == StRequest);
    csrReq.write = reqWrite;
    csrReq.block = reqBlock;
    csrReq.regIdx = reqReg;
    csrReq.wData = reqWData;
  end

  // ******************************
  // Transaction FSM
  // ******************************
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state <= StIdle;
    end else if (resetTop) begin
      state <= StIdle;
    end else begin
      case (state)
        StIdle: begin
          if (writeGo || readGo) begin
            state <= StRequest;
          end
        end
        StRequest: begin
          if (csrRsp.ready) begin
            state <= reqWrite ? StRespWrite : StRespRead;
          end
        end
        StRespWrite: begin
          if (axilReq.bReady) begin
            state <= StIdle;
          end
        end
        default: begin
          if (axilReq.rReady) begin
            state <= StIdle;
          end
        end
      endcase
    end
  end

  // Captured address, data and response
  always_ff @(posedge clock) begin
    if (writeGo) begin
      reqWrite <= 1'b1;
      reqBlock <= axilReq.awAddr[2+cosPkg::RegW +: cosPkg::BlockW];
      reqReg <= axilReq.awAddr[2 +: cosPkg::RegW];
      reqWData <= axilReq.wData;
    end else if (readGo) begin
      reqWrite <= 1'b0;
      reqBlock <= axilReq.arAddr[2+cosPkg::RegW +: cosPkg::BlockW];
      reqReg <= axilReq.arAddr[2 +: cosPkg::RegW];
    end
    if ((state == StRequest) && csrRsp.ready) begin
      respCode <= csrRsp.error ? cosPkg::RespSlvErr : cosPkg::RespOkay;
      rDataQ <= csrRsp.rData;
    end
  end

endmodule

//--- src/cosCsrSplitter.sv
// CSR block decoder; routes requests to the LED and GPIO blocks and holds the tree-control registers
`timescale 1ns/1ps

module cosCsrSplitter (
  input  logic clock,
  input  logic arstN,
  input  logic resetTop,
  input  cosPkg::csrReqT csrReq,
  output cosPkg::csrRspT csrRsp,
  output logic resetRequest,
  output logic ledSel,
  output logic gpioSel,
  output logic blkWrite,
  output logic [cosPkg::RegW-1:0] blkReg,
  output logic [cosPkg::DataW-1:0] blkWData,
  input  logic [cosPkg::DataW-1:0] ledRData,
  input  logic [cosPkg::DataW-1:0] gpioRData
);

  logic accept;
  logic treeHit;
  logic known;
  logic ready;
  logic error;
  logic [cosPkg::BlockW-1:0] respBlock;
  logic [cosPkg::DataW-1:0] treeRData;
  logic [cosPkg::DataW-1:0] scratch;

  // One accept per request, ready blocks a second one
  assign accept = csrReq.valid && !ready;
  assign treeHit = accept && (csrReq.block == cosPkg::BlockTree);
  assign known = (csrReq.block == cosPkg::BlockTree) || (csrReq.block == cosPkg::BlockLed) ||
                 (csrReq.block == cosPkg::BlockGpio);

  assign ledSel = accept && (csrReq.block == cosPkg::BlockLed);
  assign gpioSel = accept && (csrReq.block == cosPkg::BlockGpio);
  assign blkWrite = csrReq.write;
  assign blkReg = csrReq.regIdx;
  assign blkWData = csrReq.wData;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      ready <= 1'b0;
      error <= 1'b0;
      resetRequest <= 1'b0;
      scratch <= '0;
    end else if (resetTop) begin
      ready <= 1'b0;
      error <= 1'b0;
      resetRequest <= 1'b0;
      scratch <= '0;
    end else begin
      ready <= accept;
      error <= accept && !known;
      resetRequest <= treeHit && csrReq.write && (csrReq.regIdx == cosPkg::RegReset) &&
                      csrReq.wData[0];
      if (treeHit && csrReq.write && (csrReq.regIdx == cosPkg::RegScratch)) begin
        scratch <= csrReq.wData;
      end
    end
  end

  // Tree read data, lines up with the block read data
  always_ff @(posedge clock) begin
    if (accept) begin
      respBlock <= csrReq.block;
      case (csrReq.regIdx)
        cosPkg::RegId: treeRData <= cosPkg::CosIdValue;
        cosPkg::RegScratch: treeRData <= scratch;
        default: treeRData <= '0;
      endcase
    end
  end

  always_comb begin
    csrRsp.ready = ready;
    csrRsp.error = error;
    case (respBlock)
      cosPkg::BlockTree: csrRsp.rData = treeRData;
      cosPkg::BlockLed: csrRsp.rData = ledRData;
      cosPkg::BlockGpio: csrRsp.rData = gpioRData;
      default: csrRsp.rData = '0;
    endcase
  end

endmodule

//--- src/cosLed.sv
// LED controller block; per-LED 8-bit brightness registers driving PWM outputs from one counter
`timescale 1ns/1ps

module cosLed #(
  parameter int LedCount = 4
) (
  input  logic clock,
  input  logic arstN,
  input  logic resetTop,
  input  logic sel,
  input  logic write,
  input  logic [cosPkg::RegW-1:0] regIdx,
  input  logic [cosPkg::DataW-1:0] wData,
  output logic [cosPkg::DataW-1:0] rData,
  output logic [LedCount-1:0] ledOut
);

  logic [LedCount-1:0][cosPkg::LedMaxW-1:0] bright;
  logic [cosPkg::LedMaxW-1:0] pwmCount;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      bright <= '0;
      pwmCount <= '0;
    end else if (resetTop) begin
      bright <= '0;
      pwmCount <= '0;
    end else begin
      pwmCount <= pwmCount + 1'b1;
      for (int i = 0; i < LedCount; i++) begin
        if (sel && write && (regIdx == i)) begin
          bright[i] <= wData[cosPkg::LedMaxW-1:0];
        end
      end
    end
  end

  // Registers past LedCount read zero
  always_ff @(posedge clock) begin
    if (sel) begin
      rData <= '0;
      for (int i = 0; i < LedCount; i++) begin
        if (regIdx == i) begin
          rData[cosPkg::LedMaxW-1:0] <= bright[i];
        end
      end
    end
  end

  // Brightness B is on for B of every 256 counts
  always_comb begin
    for (int i = 0; i < LedCount; i++) begin
      ledOut[i] = (pwmCount < bright[i]);
    end
  end

endmodule

//--- src/cosGpio.sv
// GPIO controller block; output and tristate registers for the pins plus synchronized input readback
`timescale 1ns/1ps

module cosGpio #(
  parameter int GpioCount = 8
) (
  input  logic clock,
  input  logic arstN,
  input  logic resetTop,
  input  logic sel,
  input  logic write,
  input  logic [cosPkg::RegW-1:0] regIdx,
  input  logic [cosPkg::DataW-1:0] wData,
  output logic [cosPkg::DataW-1:0] rData,
  output logic [GpioCount-1:0] gpioOut,
  output logic [GpioCount-1:0] gpioTristate,
  input  logic [GpioCount-1:0] gpioIn
);

  logic [GpioCount-1:0] inMeta;
  logic [GpioCount-1:0] inSync;

  // Pins come out of reset undriven
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      gpioOut <= '0;
      gpioTristate <= '1;
    end else if (resetTop) begin
      gpioOut <= '0;
      gpioTristate <= '1;
    end else if (sel && write) begin
      if (regIdx == cosPkg::RegGpioOut) begin
        gpioOut <= wData[GpioCount-1:0];
      end
      if (regIdx == cosPkg::RegGpioTristate) begin
        gpioTristate <= wData[GpioCount-1:0];
      end
    end
  end

  // Two-flop input synchronizer, second stage is the readable input register
  always_ff @(posedge clock) begin
    inMeta <= gpioIn;
    inSync <= inMeta;
  end

  always_ff @(posedge clock) begin
    if (sel) begin
      rData <= '0;
      case (regIdx)
        cosPkg::RegGpioOut: rData[GpioCount-1:0] <= gpioOut;
        cosPkg::RegGpioTristate: rData[GpioCount-1:0] <= gpioTristate;
        cosPkg::RegGpioIn: rData[GpioCount-1:0] <= inSync;
        default: rData <= '0;
      endcase
    end
  end

endmodule

//--- src/cosTop.sv
// Control shell top level; connects the AXI4-Lite slave, CSR splitter, reset stretcher, LED and GPIO
`timescale 1ns/1ps

module cosTop #(
  parameter int LedCount = 4,
  parameter int GpioCount = 8
) (
  input  logic clock,
  input  logic arstN,
  input  cosPkg::axilReqT axilReq,
  output cosPkg::axilRspT axilRsp,
  output logic [LedCount-1:0] ledOut,
  output logic [GpioCount-1:0] gpioOut,
  output logic [GpioCount-1:0] gpioTristate,
  input  logic [GpioCount-1:0] gpioIn
);

  logic resetTop;
  logic resetRequest;
  cosPkg::csrReqT csrReq;
  cosPkg::csrRspT csrRsp;
  logic ledSel;
  logic gpioSel;
  logic blkWrite;
  logic [cosPkg::RegW-1:0] blkReg;
  logic [cosPkg::DataW-1:0] blkWData;
  logic [cosPkg::DataW-1:0] ledRData;
  logic [cosPkg::DataW-1:0] gpioRData;

  // ******************************
  // Reset and control path
  // ******************************
  cosResetStretch uReset (
    .clock(clock), .arstN(arstN), .resetRequest(resetRequest), .resetTop(resetTop)
  );

  cosAxilControl uAxilControl (
    .clock(clock), .arstN(arstN), .resetTop(resetTop),
    .axilReq(axilReq), .axilRsp(axilRsp), .csrReq(csrReq), .csrRsp(csrRsp)
  );

  cosCsrSplitter uSplitter (
    .clock(clock), .arstN(arstN), .resetTop(resetTop),
    .csrReq(csrReq), .csrRsp(csrRsp), .resetRequest(resetRequest),
    .ledSel(ledSel), .gpioSel(gpioSel), .blkWrite(blkWrite), .blkReg(blkReg),
    .blkWData(blkWData), .ledRData(ledRData), .gpioRData(gpioRData)
  );

  // ******************************
  // Blocks
  // ******************************
  cosLed #(.LedCount(LedCount)) uLed (
    .clock(clock), .arstN(arstN), .resetTop(resetTop),
    .sel(ledSel), .write(blkWrite), .regIdx(blkReg), .wData(blkWData),
    .rData(ledRData), .ledOut(ledOut)
  );

  cosGpio #(.GpioCount(GpioCount)) uGpio (
    .clock(clock), .arstN(arstN), .resetTop(resetTop),
    .sel(gpioSel), .write(blkWrite), .regIdx(blkReg), .wData(blkWData),
    .rData(gpioRData), .gpioOut(gpioOut), .gpioTristate(gpioTristate), .gpioIn(gpioIn)
  );

endmodule

//--- dv/cosTb.sv
// Random-stimulus testbench for the control shell; drives AXI4-Lite traffic and checks a register model
`timescale 1ns/1ps

module cosTb;

  localparam int LedCount = 4;
  localparam int GpioCount = 8;
  localparam int RandTxns = 120;
  localparam int TxnBudget = 200;
  localparam int SoftResetWait = cosPkg::ResetStartCycles + cosPkg::ResetCycles + 10;
  localparam int WatchdogCycles = TxnBudget * 40 + 4 + cosPkg::ResetCycles + SoftResetWait +
                                  3 * 256;

  logic clock;
  logic arstN;
  cosPkg::axilReqT axilReq;
  cosPkg::axilRspT axilRsp;
  logic [LedCount-1:0] ledOut;
  logic [GpioCount-1:0] gpioOut;
  logic [GpioCount-1:0] gpioTristate;
  logic [GpioCount-1:0] gpioIn;

  int seed;
  int errors;
  int checks;

  // Register model
  logic [cosPkg::DataW-1:0] scratchM;
  logic [cosPkg::LedMaxW-1:0] brightM [LedCount];
  logic [GpioCount-1:0] gpioOutM;
  logic [GpioCount-1:0] gpioTriM;
  logic [GpioCount-1:0] gpioInM;

  cosTop UUT (
    .clock(clock), .arstN(arstN), .axilReq(axilReq), .axilRsp(axilRsp),
    .ledOut(ledOut), .gpioOut(gpioOut), .gpioTristate(gpioTristate), .gpioIn(gpioIn)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clock);
    $display("Watchdog expired, a bus handshake never completed");
    $display("TB FAILED");
    $finish;
  end

  function automatic int unsigned pickBelow(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Low two address bits are ignored by the DUT and get random values
  function automatic logic [cosPkg::AddrW-1:0] csrAddr(input int unsigned block,
                                                       input int unsigned regIdx);
    logic [1:0] low;
    low = 2'(pickBelow(4));
    return {block[3:0], regIdx[5:0], low};
  endfunction

  // ******************************
  // Model
  // ******************************
  task automatic resetModel();
    scratchM = '0;
    gpioOutM = '0;
    gpioTriM = '1;
    for (int i = 0; i < LedCount; i++) begin
      brightM[i] = '0;
    end
  endtask

  task automatic updateModel(input int unsigned block, input int unsigned regIdx,
                             input logic [cosPkg::DataW-1:0] data);
    if (block == cosPkg::BlockTree && regIdx == cosPkg::RegScratch) begin
      scratchM = data;
    end else if (block == cosPkg::BlockLed && regIdx < LedCount) begin
      brightM[regIdx] = data[cosPkg::LedMaxW-1:0];
    end else if (block == cosPkg::BlockGpio && regIdx == cosPkg::RegGpioOut) begin
      gpioOutM = data[GpioCount-1:0];
    end else if (block == cosPkg::BlockGpio && regIdx == cosPkg::RegGpioTristate) begin
      gpioTriM = data[GpioCount-1:0];
    end
  endtask

  // Unknown registers and unknown blocks read zero
  function automatic logic [cosPkg::DataW-1:0] expectData(input int unsigned block,
                                                          input int unsigned regIdx);
    logic [cosPkg::DataW-1:0] value;
    value = '0;
    if (block == cosPkg::BlockTree) begin
      if (regIdx == cosPkg::RegId) begin
        value = cosPkg::CosIdValue;
      end else if (regIdx == cosPkg::RegScratch) begin
        value = scratchM;
      end
    end else if (block == cosPkg::BlockLed && regIdx < LedCount) begin
      value[cosPkg::LedMaxW-1:0] = brightM[regIdx];
    end else if (block == cosPkg::BlockGpio) begin
      if (regIdx == cosPkg::RegGpioOut) begin
        value[GpioCount-1:0] = gpioOutM;
      end else if (regIdx == cosPkg::RegGpioTristate) begin
        value[GpioCount-1:0] = gpioTriM;
      end else if (regIdx == cosPkg::RegGpioIn) begin
        value[GpioCount-1:0] = gpioInM;
      end
    end
    return value;
  endfunction

  function automatic logic [1:0] expectResp(input int unsigned block);
    return (block <= 2) ? cosPkg::RespOkay : cosPkg::RespSlvErr;
  endfunction

  task automatic compareWord(input string name, input logic [cosPkg::DataW-1:0] got,
                             input logic [cosPkg::DataW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ******************************
  // AXI4-Lite driver
  // ******************************
  // Tasks start and end 1 ns after a rising edge
  // Handshakes are sampled at the falling edge
  task automatic writeReg(input logic [cosPkg::AddrW-1:0] addr,
                          input logic [cosPkg::DataW-1:0] data, input bit pressure,
                          output logic [1:0] resp);
    repeat (pickBelow(4)) begin
      @(posedge clock);
      #1;
    end
    axilReq.awValid = 1'b1;
    axilReq.awAddr = addr;
    axilReq.wValid = 1'b1;
    axilReq.wData = data;
    do @(negedge clock); while (!axilRsp.awReady);
    // Address and data are accepted in the same cycle
    compareWord("wReady", axilRsp.wReady, 1'b1);
    @(posedge clock);
    #1;
    axilReq.awValid = 1'b0;
    axilReq.wValid = 1'b0;
    axilReq.bReady = pressure ? 1'(pickBelow(2)) : 1'b1;
    @(negedge clock);
    while (!(axilRsp.bValid && axilReq.bReady)) begin
      @(posedge clock);
      #1;
      axilReq.bReady = pressure ? 1'(pickBelow(2)) : 1'b1;
      @(negedge clock);
    end
    resp = axilRsp.bResp;
    @(posedge clock);
    #1;
    axilReq.bReady = 1'b0;
  endtask

  task automatic readReg(input logic [cosPkg::AddrW-1:0] addr,
                         output logic [cosPkg::DataW-1:0] data, output logic [1:0] resp);
    repeat (pickBelow(4)) begin
      @(posedge clock);
      #1;
    end
    axilReq.arValid = 1'b1;
    axilReq.arAddr = addr;
    do @(negedge clock); while (!axilRsp.arReady);
    @(posedge clock);
    #1;
    axilReq.arValid = 1'b0;
    axilReq.rReady = 1'(pickBelow(2));
    @(negedge clock);
    while (!(axilRsp.rValid && axilReq.rReady)) begin
      @(posedge clock);
      #1;
      axilReq.rReady = 1'(pickBelow(2));
      @(negedge clock);
    end
    data = axilRsp.rData;
    resp = axilRsp.rResp;
    @(posedge clock);
    #1;
    axilReq.rReady = 1'b0;
  endtask

  task automatic checkWrite(input int unsigned block, input int unsigned regIdx,
                            input logic [cosPkg::DataW-1:0] data);
    logic [1:0] resp;
    writeReg(csrAddr(block, regIdx), data, 1'b1, resp);
    compareWord($sformatf("bResp[%0d:%0d]", block, regIdx), resp, expectResp(block));
    updateModel(block, regIdx, data);
  endtask

  task automatic checkRead(input int unsigned block, input int unsigned regIdx);
    logic [cosPkg::DataW-1:0] data;
    logic [1:0] resp;
    readReg(csrAddr(block, regIdx), data, resp);
    compareWord($sformatf("rData[%0d:%0d]", block, regIdx), data, expectData(block, regIdx));
    compareWord($sformatf("rResp[%0d:%0d]", block, regIdx), resp, expectResp(block));
  endtask

  task automatic checkAllRegs();
    checkRead(cosPkg::BlockTree, cosPkg::RegId);
    checkRead(cosPkg::BlockTree, cosPkg::RegScratch);
    for (int i = 0; i < LedCount; i++) begin
      checkRead(cosPkg::BlockLed, i);
    end
    checkRead(cosPkg::BlockGpio, cosPkg::RegGpioOut);
    checkRead(cosPkg::BlockGpio, cosPkg::RegGpioTristate);
    checkRead(cosPkg::BlockGpio, cosPkg::RegGpioIn);
  endtask

  task automatic checkPins(input bit ledsOff);
    @(negedge clock);
    compareWord("gpioOut", gpioOut, gpioOutM);
    compareWord("gpioTristate", gpioTristate, gpioTriM);
    if (ledsOff) begin
      compareWord("ledOut", ledOut, '0);
    end
    @(posedge clock);
    #1;
  endtask

  task automatic checkResetState();
    resetModel();
    checkPins(1'b1);
    checkAllRegs();
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial begin
    int unsigned block;
    int unsigned regIdx;
    int unsigned led;
    int unsigned bright;
    int unsigned highCount;
    logic [1:0] resp;
    seed = 32'h3238_cdde;
    errors = 0;
    checks = 0;
    arstN = 1'b0;
    axilReq = '0;
    gpioIn = '0;
    gpioInM = '0;
    resetModel();
    repeat (4) @(posedge clock);
    #1;
    arstN = 1'b1;

    // Ready stays low until the stretched reset ends
    checkResetState();

    for (int i = 0; i < RandTxns; i++) begin
      block = pickBelow(3);
      regIdx = pickBelow(8);
      if (block == cosPkg::BlockTree && regIdx == cosPkg::RegReset) begin
        regIdx = 3;
      end
      if (pickBelow(2) == 1) begin
        checkWrite(block, regIdx, $random(seed));
      end else begin
        checkRead(block, regIdx);
      end
    end
    checkPins(1'b0);

    // Unknown blocks, then unknown registers in known blocks
    for (int b = 3; b < 16; b++) begin
      checkWrite(b, pickBelow(64), $random(seed));
      checkRead(b, pickBelow(64));
    end
    checkWrite(cosPkg::BlockTree, 3 + pickBelow(61), $random(seed));
    checkRead(cosPkg::BlockTree, 3 + pickBelow(61));
    checkWrite(cosPkg::BlockLed, LedCount + pickBelow(64 - LedCount), $random(seed));
    checkRead(cosPkg::BlockLed, LedCount + pickBelow(64 - LedCount));
    checkWrite(cosPkg::BlockGpio, 3 + pickBelow(61), $random(seed));
    checkRead(cosPkg::BlockGpio, 3 + pickBelow(61));
    checkAllRegs();

    // GPIO pins and synchronized input
    checkWrite(cosPkg::BlockGpio, cosPkg::RegGpioOut, $random(seed));
    checkWrite(cosPkg::BlockGpio, cosPkg::RegGpioTristate, $random(seed));
    checkPins(1'b0);
    gpioInM = GpioCount'($random(seed));
    gpioIn = gpioInM;
    repeat (4) begin
      @(posedge clock);
      #1;
    end
    checkRead(cosPkg::BlockGpio, cosPkg::RegGpioIn);

    // PWM duty over one full counter period
    for (int t = 0; t < 2; t++) begin
      led = pickBelow(LedCount);
      bright = pickBelow(256);
      checkWrite(cosPkg::BlockLed, led, bright);
      highCount = 0;
      repeat (256) begin
        @(negedge clock);
        if (ledOut[led]) begin
          highCount++;
        end
      end
      compareWord($sformatf("ledOut[%0d] high cycles", led), highCount, bright);
      @(posedge clock);
      #1;
    end

    // Soft reset whose write response drains before the internal reset
    checkWrite(cosPkg::BlockTree, cosPkg::RegScratch, $random(seed) | 1);
    writeReg(csrAddr(cosPkg::BlockTree, cosPkg::RegReset), 32'h1, 1'b0, resp);
    compareWord("bResp soft reset", resp, cosPkg::RespOkay);
    repeat (SoftResetWait) begin
      @(posedge clock);
      #1;
    end
    checkResetState();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
src/cosPkg.sv
src/cosResetStretch.sv
src/cosAxilControl.sv
src/cosCsrSplitter.sv
src/cosLed.sv
src/cosGpio.sv
src/cosTop.sv
dv/cosTb.sv

//--- Bender.yml
package:
  name: cos_shell

sources:
  - files:
      - src/cosPkg.sv
      - src/cosResetStretch.sv
      - src/cosAxilControl.sv
      - src/cosCsrSplitter.sv
      - src/cosLed.sv
      - src/cosGpio.sv
      - src/cosTop.sv
  - target: simulation
    files:
      - dv/cosTb.sv
